//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_mem_top
FILELIST = tb.f
BUILD = obj_dir
BIN = $(BUILD)/V$(TOP)
SOURCES = $(shell grep '\.sv$$' $(FILELIST)) tsconf_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(BUILD)

//--- cpu_port.sv
`timescale 1ns/100ps

module cpu_port (
	input  logic fclk,
	input  logic rst_n,
	input  logic cpu_req,
	input  tsconf_pkg::cpu_cmd_s cpu_cmd,
	input  logic cpu_next,
	input  logic cpu_strobe,
	input  tsconf_pkg::dram_word_t dram_rddata,
	output logic cpu_ack,
	output tsconf_pkg::byte_t cpu_rddata,
	output logic cpu_want,
	output tsconf_pkg::mem_req_s cpu_slot
);

	tsconf_pkg::cpu_state_t state;
	logic hi_byte;

	// byte access mapped onto one word cycle
	always_comb begin
		hi_byte = cpu_cmd.addr[0];
		cpu_slot.addr = tsconf_pkg::word_addr_t'(cpu_cmd.addr >> 1);
		cpu_slot.rnw = cpu_cmd.rnw;
		cpu_slot.bsel = hi_byte ? 2'b10 : 2'b01;
		cpu_slot.wrdata = {cpu_cmd.wrdata, cpu_cmd.wrdata};
		cpu_want = state == tsconf_pkg::cs_want;
		cpu_ack = state == tsconf_pkg::cs_ack;
	end

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			state <= tsconf_pkg::cs_idle;
		end else begin
			case (state)
				tsconf_pkg::cs_idle:
					if (cpu_req)
						state <= tsconf_pkg::cs_want;
				tsconf_pkg::cs_want:
					if (cpu_next)
						state <= cpu_cmd.rnw ? tsconf_pkg::cs_rdwait : tsconf_pkg::cs_ack;
				tsconf_pkg::cs_rdwait:
					if (cpu_strobe)
						state <= tsconf_pkg::cs_ack;
				// hold ack until the host lets go of req
				tsconf_pkg::cs_ack:
					if (!cpu_req)
						state <= tsconf_pkg::cs_idle;
				default:
					state <= tsconf_pkg::cs_idle;
			endcase
		end
	end

	always_ff @(posedge fclk) begin
		if (state == tsconf_pkg::cs_rdwait && cpu_strobe)
			cpu_rddata <= hi_byte ? dram_rddata[15:8] : dram_rddata[7:0];
	end

endmodule

//--- dma_copy.sv
`timescale 1ns/100ps
`include "tsconf_settings.svh"

module dma_copy (
	input  logic fclk,
	input  logic rst_n,
	input  logic dma_req,
	input  tsconf_pkg::dma_cmd_s dma_cmd,
	input  logic dma_next,
	input  logic dma_strobe,
	input  tsconf_pkg::dram_word_t dram_rddata,
	output logic dma_ack,
	output logic dma_want,
	output tsconf_pkg::mem_req_s dma_slot
);

	tsconf_pkg::dma_state_t state;
	tsconf_pkg::dma_len_t idx;
	tsconf_pkg::dma_len_t idx_inc;
	tsconf_pkg::word_addr_t offs;
	tsconf_pkg::dram_word_t hold;
	logic writing;

	always_comb begin
		idx_inc = idx + 1'b1;
		offs = {{(`DRAM_ADDR_W - `DMA_LEN_W){1'b0}}, idx};
		writing = state == tsconf_pkg::ds_wr;

		dma_want = state == tsconf_pkg::ds_rd || writing;
		dma_ack = state == tsconf_pkg::ds_ack;

		// same index on both sides of the copy
		dma_slot.addr = (writing ? dma_cmd.dst : dma_cmd.src) + offs;
		dma_slot.rnw = !writing;
		dma_slot.bsel = 2'b11;
		dma_slot.wrdata = hold;
	end

	////////////////////////////////////////
	// copy sequencer
	////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			state <= tsconf_pkg::ds_idle;
			idx <= '0;
		end else begin
			case (state)
				tsconf_pkg::ds_idle:
					if (dma_req) begin
						idx <= '0;
						// empty block, nothing to move
						if (dma_cmd.len == '0)
							state <= tsconf_pkg::ds_ack;
						else
							state <= tsconf_pkg::ds_rd;
					end
				tsconf_pkg::ds_rd:
					if (dma_next)
						state <= tsconf_pkg::ds_rdwait;
				tsconf_pkg::ds_rdwait:
					if (dma_strobe)
						state <= tsconf_pkg::ds_wr;
				tsconf_pkg::ds_wr:
					if (dma_next) begin
						idx <= idx_inc;
						if (idx_inc == dma_cmd.len)
							state <= tsconf_pkg::ds_ack;
						else
							state <= tsconf_pkg::ds_rd;
					end
				tsconf_pkg::ds_ack:
					if (!dma_req)
						state <= tsconf_pkg::ds_idle;
				default:
					state <= tsconf_pkg::ds_idle;
			endcase
		end
	end

	// word in transit between its read and its write
	always_ff @(posedge fclk) begin
		if (state == tsconf_pkg::ds_rdwait && dma_strobe)
			hold <= dram_rddata;
	end

endmodule

//--- dram_arbiter.sv
`timescale 1ns/100ps
`include "tsconf_settings.svh"

module dram_arbiter (
	input  logic fclk,
	input  logic rst_n,
	input  logic cpu_want,
	input  tsconf_pkg::mem_req_s cpu_slot,
	input  logic dma_want,
	input  tsconf_pkg::mem_req_s dma_slot,
	output logic cpu_next,
	output logic cpu_strobe,
	output logic dma_next,
	output logic dma_strobe,
	output tsconf_pkg::dram_cycle_s cycle,
	output tsconf_pkg::phase_t phase
);

	localparam int RFSH_W = $clog2(`REFRESH_INTERVAL);

	logic [RFSH_W-1:0] rfsh_cnt;
	logic rfsh_tick;
	logic rfsh_pend;
	logic c3;
	logic owner_cpu;
	tsconf_pkg::mem_req_s win;
	tsconf_pkg::cyc_kind_t kind_nxt;

	////////////////////////////////////////
	// phase counter and refresh timer
	////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			phase <= tsconf_pkg::ph_c0;
			rfsh_cnt <= '0;
			rfsh_pend <= 1'b0;
		end else begin
			phase <= tsconf_pkg::phase_t'(phase + 1'b1);
			rfsh_cnt <= rfsh_tick ? '0 : rfsh_cnt + 1'b1;
			// a new tick wins over the grant of the old one
			if (rfsh_tick)
				rfsh_pend <= 1'b1;
			else if (c3)
				rfsh_pend <= 1'b0;
		end
	end

	////////////////////////////////////////
	// fixed priority: refresh, cpu, dma
	////////////////////////////////////////

	always_comb begin
		rfsh_tick = rfsh_cnt == RFSH_W'(`REFRESH_INTERVAL - 1);
		c3 = phase == tsconf_pkg::ph_c3;
		win = cpu_want ? cpu_slot : dma_slot;

		if (rfsh_pend)
			kind_nxt = tsconf_pkg::cyc_refresh;
		else if (cpu_want || dma_want)
			kind_nxt = win.rnw ? tsconf_pkg::cyc_read : tsconf_pkg::cyc_write;
		else
			kind_nxt = tsconf_pkg::cyc_idle;

		cpu_next = c3 && !rfsh_pend && cpu_want;
		dma_next = c3 && !rfsh_pend && !cpu_want && dma_want;

		// read data shows up at c3 of the granted cycle
		cpu_strobe = c3 && cycle.kind == tsconf_pkg::cyc_read && owner_cpu;
		dma_strobe = c3 && cycle.kind == tsconf_pkg::cyc_read && !owner_cpu;
	end

	// latch the winner for the next four phases
	always_ff @(posedge fclk) begin
		if (!rst_n) begin
			cycle.kind <= tsconf_pkg::cyc_idle;
			owner_cpu <= 1'b0;
		end else if (c3) begin
			cycle.kind <= kind_nxt;
			owner_cpu <= cpu_want;
		end
	end

	always_ff @(posedge fclk) begin
		if (c3) begin
			cycle.addr <= win.addr;
			cycle.bsel <= win.bsel;
			cycle.wrdata <= win.wrdata;
		end
	end

endmodule

//--- dram_ctrl.sv
`timescale 1ns/100ps
`include "tsconf_settings.svh"

module dram_ctrl (
	input  logic fclk,
	input  logic rst_n,
	input  tsconf_pkg::dram_cycle_s cycle,
	input  tsconf_pkg::phase_t phase,
	input  tsconf_pkg::dram_word_t dram_din,
	output tsconf_pkg::dram_word_t dram_rddata,
	output tsconf_pkg::dram_word_t dram_dout,
	output logic dram_oe,
	output tsconf_pkg::ra_t dram_ra,
	output logic rwe_n,
	output logic rucas_n,
	output logic rlcas_n,
	output logic rras0_n,
	output logic rras1_n
);

	tsconf_pkg::ra_t row;
	tsconf_pkg::ra_t col;
	logic bank;
	logic is_rd;
	logic is_wr;
	logic is_rf;
	logic acc;
	// c0..c2 and c1..c2 windows
	logic win_long;
	logic win_short;
	logic ras_acc;
	logic ucas_acc;
	logic lcas_acc;

	always_comb begin
		row = cycle.addr[2*`DRAM_RA_W-1:`DRAM_RA_W];
		col = cycle.addr[`DRAM_RA_W-1:0];
		bank = cycle.addr[`BANK_BIT];

		is_rd = cycle.kind == tsconf_pkg::cyc_read;
		is_wr = cycle.kind == tsconf_pkg::cyc_write;
		is_rf = cycle.kind == tsconf_pkg::cyc_refresh;
		acc = is_rd || is_wr;

		win_long = phase != tsconf_pkg::ph_c3;
		win_short = phase == tsconf_pkg::ph_c1 || phase == tsconf_pkg::ph_c2;

		// normal access: ras at c0, cas at c1
		ras_acc = acc && win_long;
		ucas_acc = (is_rd || (is_wr && cycle.bsel[1])) && win_short;
		lcas_acc = (is_rd || (is_wr && cycle.bsel[0])) && win_short;

		// refresh turns it around, cas first, both banks
		rras0_n = !((ras_acc && !bank) || (is_rf && win_short));
		rras1_n = !((ras_acc && bank) || (is_rf && win_short));
		rucas_n = !(ucas_acc || (is_rf && win_long));
		rlcas_n = !(lcas_acc || (is_rf && win_long));

		rwe_n = !(is_wr && phase != tsconf_pkg::ph_c0);
		dram_oe = is_wr && phase != tsconf_pkg::ph_c0;
		dram_dout = cycle.wrdata;
		dram_ra = (phase == tsconf_pkg::ph_c0) ? row : col;
	end

	////////////////////////////////////////
	// read capture
	////////////////////////////////////////

	// data is settled by the end of c2
	always_ff @(posedge fclk) begin
		if (!rst_n)
			dram_rddata <= '0;
		else if (is_rd && phase == tsconf_pkg::ph_c2)
			dram_rddata <= dram_din;
	end

endmodule

//--- dram_model.sv
`timescale 1ns/100ps

module dram_model (
	input  logic fclk,
	input  tsconf_pkg::dram_word_t dram_dout,
	input  logic dram_oe,
	input  tsconf_pkg::ra_t dram_ra,
	input  logic rwe_n,
	input  logic rucas_n,
	input  logic rlcas_n,
	input  logic rras0_n,
	input  logic rras1_n,
	output tsconf_pkg::dram_word_t dram_din,
	output int rd_count,
	output int wr_count,
	output int rf_count,
	output int bad_count
);

	tsconf_pkg::dram_word_t mem [int];
	tsconf_pkg::ra_t row;
	logic bank;
	logic ras, ucas, lcas;
	logic ras_q, ucas_q, lcas_q;

	// unwritten words read back a pattern of their full address
	function automatic tsconf_pkg::dram_word_t peek(input int a);
		if (mem.exists(a))
			return mem[a];
		return 16'(a * 40503) ^ 16'(a >> 11);
	endfunction

	initial begin
		dram_din = '0;
		rd_count = 0;
		wr_count = 0;
		rf_count = 0;
		bad_count = 0;
		ras_q = 1'b0;
		ucas_q = 1'b0;
		lcas_q = 1'b0;
	end

	always_comb begin
		ras = !rras0_n || !rras1_n;
		ucas = !rucas_n;
		lcas = !rlcas_n;
	end

	always @(posedge fclk) begin : decode
		int addr;
		tsconf_pkg::dram_word_t w;
		ras_q <= ras;
		ucas_q <= ucas;
		lcas_q <= lcas;
		if (ras && !ras_q) begin
			if (ucas_q || lcas_q) begin
				// cas already down, so a cbr refresh
				rf_count <= rf_count + 1;
				if (!(ucas_q && lcas_q && !rras0_n && !rras1_n))
					bad_count <= bad_count + 1;
			end else begin
				row <= dram_ra;
				bank <= !rras1_n;
				if (ucas || lcas)
					bad_count <= bad_count + 1;
			end
		end else if (ras && ras_q && ((ucas && !ucas_q) || (lcas && !lcas_q))) begin
			addr = int'({bank, row, dram_ra});
			if (!rwe_n) begin
				w = peek(addr);
				if (ucas)
					w[15:8] = dram_dout[15:8];
				if (lcas)
					w[7:0] = dram_dout[7:0];
				mem[addr] = w;
				wr_count <= wr_count + 1;
				if (!dram_oe)
					bad_count <= bad_count + 1;
			end else begin
				dram_din <= peek(addr);
				rd_count <= rd_count + 1;
				// the DRAM drives the bus on a read
				if (dram_oe)
					bad_count <= bad_count + 1;
			end
		end
	end

endmodule

//--- mem_cases.txt
# W byte_addr data | R byte_addr expected | D src dst len | P src dst len cpu_byte_base
# I idle_cycles; all values hex, dma addresses are word addresses
W 000100 a5
W 000101 3c
W 000100 77
R 000100 77
R 000101 3c
W 3ffffe 5a
W 3fffff c3
R 3ffffe 5a
R 3fffff c3
D 001000 002000 10
D 001000 003000 0
P 004000 005000 20 020000
I 400
D 100040 000800 4
R 000100 77
R 000101 3c

//--- mem_top.sv
`timescale 1ns/100ps

module mem_top (
	input  logic fclk,
	input  logic rst_n,
	input  logic cpu_req,
	input  tsconf_pkg::cpu_cmd_s cpu_cmd,
	input  logic dma_req,
	input  tsconf_pkg::dma_cmd_s dma_cmd,
	output logic cpu_ack,
	output tsconf_pkg::byte_t cpu_rddata,
	output logic dma_ack,
	input  tsconf_pkg::dram_word_t dram_din,
	output tsconf_pkg::dram_word_t dram_dout,
	output logic dram_oe,
	output tsconf_pkg::ra_t dram_ra,
	output logic rwe_n,
	output logic rucas_n,
	output logic rlcas_n,
	output logic rras0_n,
	output logic rras1_n
);

	logic cpu_want;
	logic cpu_next;
	logic cpu_strobe;
	tsconf_pkg::mem_req_s cpu_slot;
	logic dma_want;
	logic dma_next;
	logic dma_strobe;
	tsconf_pkg::mem_req_s dma_slot;
	tsconf_pkg::dram_cycle_s cycle;
	tsconf_pkg::phase_t phase;
	tsconf_pkg::dram_word_t dram_rddata;

	dram_arbiter dram_arbiter_inst (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.cpu_want   (cpu_want),
		.cpu_slot   (cpu_slot),
		.dma_want   (dma_want),
		.dma_slot   (dma_slot),
		.cpu_next   (cpu_next),
		.cpu_strobe (cpu_strobe),
		.dma_next   (dma_next),
		.dma_strobe (dma_strobe),
		.cycle      (cycle),
		.phase      (phase)
	);

	dram_ctrl dram_ctrl_inst (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.cycle       (cycle),
		.phase       (phase),
		.dram_din    (dram_din),
		.dram_rddata (dram_rddata),
		.dram_dout   (dram_dout),
		.dram_oe     (dram_oe),
		.dram_ra     (dram_ra),
		.rwe_n       (rwe_n),
		.rucas_n     (rucas_n),
		.rlcas_n     (rlcas_n),
		.rras0_n     (rras0_n),
		.rras1_n     (rras1_n)
	);

	cpu_port cpu_port_inst (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.cpu_cmd     (cpu_cmd),
		.cpu_next    (cpu_next),
		.cpu_strobe  (cpu_strobe),
		.dram_rddata (dram_rddata),
		.cpu_ack     (cpu_ack),
		.cpu_rddata  (cpu_rddata),
		.cpu_want    (cpu_want),
		.cpu_slot    (cpu_slot)
	);

	dma_copy dma_copy_inst (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.dma_req     (dma_req),
		.dma_cmd     (dma_cmd),
		.dma_next    (dma_next),
		.dma_strobe  (dma_strobe),
		.dram_rddata (dram_rddata),
		.dma_ack     (dma_ack),
		.dma_want    (dma_want),
		.dma_slot    (dma_slot)
	);

endmodule

//--- tb.f
+incdir+.
tsconf_pkg.sv
dram_arbiter.sv
dram_ctrl.sv
cpu_port.sv
dma_copy.sv
mem_top.sv
dram_model.sv
tb_mem_top.sv

//--- tb_mem_top.sv
`timescale 1ns/100ps
`include "tsconf_settings.svh"

module tb_mem_top;

	// generous fclk cycles for one cpu or dma access
	localparam int ACCESS_BOUND = 40;

	typedef struct packed {
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
	} case_s;

	logic fclk = 1'b0;
	logic rst_n = 1'b0;
	logic cpu_req = 1'b0;
	tsconf_pkg::cpu_cmd_s cpu_cmd = '0;
	logic dma_req = 1'b0;
	tsconf_pkg::dma_cmd_s dma_cmd = '0;
	logic cpu_ack, dma_ack, dram_oe;
	tsconf_pkg::byte_t cpu_rddata;
	tsconf_pkg::dram_word_t dram_din, dram_dout;
	tsconf_pkg::ra_t dram_ra;
	logic rwe_n, rucas_n, rlcas_n, rras0_n, rras1_n;
	int rd_count, wr_count, rf_count, bad_count;

	case_s cases[$];
	tsconf_pkg::byte_t shadow [int];
	int errors = 0;
	int checks = 0;
	int budget = 0;

	mem_top mem_top_inst (.*);
	dram_model dram_model_inst (.*);

	always #20 fclk = ~fclk;

	task automatic tick();
		@(posedge fclk);
		#2;
	endtask

	task automatic cpu_access(input logic rnw, input int addr, input tsconf_pkg::byte_t wdata,
			output tsconf_pkg::byte_t rdata);
		cpu_cmd.addr = tsconf_pkg::byte_addr_t'(addr);
		cpu_cmd.rnw = rnw;
		cpu_cmd.wrdata = wdata;
		cpu_req = 1'b1;
		do
			tick();
		while (cpu_ack !== 1'b1);
		rdata = cpu_rddata;
		cpu_req = 1'b0;
		do
			tick();
		while (cpu_ack !== 1'b0);
	endtask

	task automatic cpu_write(input int addr, input tsconf_pkg::byte_t data);
		tsconf_pkg::byte_t unused;
		cpu_access(1'b0, addr, data, unused);
		shadow[addr] = data;
	endtask

	task automatic cpu_expect(input int addr, input tsconf_pkg::byte_t exp);
		tsconf_pkg::byte_t got;
		cpu_access(1'b1, addr, 8'h00, got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH cpu_rddata at byte %h: got %h expected %h", addr, got, exp);
		end
	endtask

	task automatic dma_run(input int src, input int dst, input int len);
		dma_cmd.src = tsconf_pkg::word_addr_t'(src);
		dma_cmd.dst = tsconf_pkg::word_addr_t'(dst);
		dma_cmd.len = tsconf_pkg::dma_len_t'(len);
		dma_req = 1'b1;
		do
			tick();
		while (dma_ack !== 1'b1);
		dma_req = 1'b0;
		do
			tick();
		while (dma_ack !== 1'b0);
	endtask

	task automatic fill_source(input int src, input int len);
		for (int i = 0; i < 2 * len; i++)
			cpu_write(2 * src + i, tsconf_pkg::byte_t'($urandom));
	endtask

	// every dst byte against the source, and the source left alone
	task automatic verify_copy(input int src, input int dst, input int len);
		tsconf_pkg::byte_t exp;
		for (int i = 0; i < 2 * len; i++) begin
			exp = shadow[2 * src + i];
			cpu_expect(2 * dst + i, exp);
			shadow[2 * dst + i] = exp;
			cpu_expect(2 * src + i, exp);
		end
	endtask

	task automatic cpu_traffic(input int base, input int n);
		for (int i = 0; i < n; i++)
			cpu_write(base + i, tsconf_pkg::byte_t'($urandom));
		for (int i = 0; i < n; i++)
			cpu_expect(base + i, shadow[base + i]);
	endtask

	task automatic load_cases();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		logic [31:0] a, b, c, d;
		fd = $fopen("mem_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open mem_cases.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			a = '0;
			b = '0;
			c = '0;
			d = '0;
			n = $sscanf(line, "%c %h %h %h %h", op, a, b, c, d);
			if (n >= 2 && op != "#")
				cases.push_back('{op, a, b, c, d});
		end
		$fclose(fd);
	endtask

	function automatic int case_cycles(input case_s c);
		case (c.op)
			"D": return (8 * int'(c.c) + 2) * ACCESS_BOUND;
			"P": return (8 * int'(c.c) + 18) * ACCESS_BOUND;
			"I": return int'(c.a) + ACCESS_BOUND;
			default: return ACCESS_BOUND;
		endcase
	endfunction

	task automatic run_case(input case_s c);
		int wr_before;
		int rf_before;
		case (c.op)
			"W": cpu_write(int'(c.a), c.b[7:0]);
			"R": cpu_expect(int'(c.a), c.b[7:0]);
			"D", "P": begin
				fill_source(int'(c.a), int'(c.c));
				wr_before = wr_count;
				if (c.op == "P") begin
					// cpu on its own region while the copy runs
					fork
						dma_run(int'(c.a), int'(c.b), int'(c.c));
						cpu_traffic(int'(c.d), 8);
					join
				end else begin
					dma_run(int'(c.a), int'(c.b), int'(c.c));
				end
				if (c.op == "D" && c.c == 0) begin
					// a write granted before ack reaches the DRAM within one DRAM cycle
					repeat (4)
						tick();
					checks++;
					assert (wr_count == wr_before) else begin
						errors++;
						$display("empty DMA copy wrote %0d words", wr_count - wr_before);
					end
				end
				verify_copy(int'(c.a), int'(c.b), int'(c.c));
			end
			"I": begin
				rf_before = rf_count;
				repeat (int'(c.a))
					tick();
				checks++;
				assert (rf_count - rf_before >= int'(c.a) / `REFRESH_INTERVAL - 1) else begin
					errors++;
					$display("only %0d refresh cycles in %0d idle cycles",
						rf_count - rf_before, c.a);
				end
			end
			default: begin
				errors++;
				$display("unknown case kind %c", c.op);
			end
		endcase
	endtask

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////

	initial begin
		wait (budget > 0);
		repeat (budget)
			@(posedge fclk);
		$display("run did not finish within %0d cycles", budget);
		$display("%0d checks, %0d errors", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h367f_973c));
		load_cases();
		budget = 300;
		foreach (cases[i])
			budget += case_cycles(cases[i]);
		repeat (5)
			@(posedge fclk);
		#2;
		rst_n = 1'b1;

		// nothing moves before the first request
		repeat (10) begin
			tick();
			checks++;
			assert (cpu_ack === 1'b0 && dma_ack === 1'b0) else begin
				errors++;
				$display("ack raised with no request pending");
			end
		end
		checks++;
		assert (rd_count == 0 && wr_count == 0) else begin
			errors++;
			$display("DRAM access seen before any request");
		end

		foreach (cases[i])
			run_case(cases[i]);

		checks++;
		assert (bad_count == 0) else begin
			errors++;
			$display("DRAM model saw %0d bad strobe sequences", bad_count);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- tsconf_pkg.sv
`include "tsconf_settings.svh"

package tsconf_pkg;

	typedef logic [`DRAM_ADDR_W-1:0] word_addr_t;
	// bit 0 picks the byte lane, 0 is the low byte
	typedef logic [`DRAM_ADDR_W:0] byte_addr_t;
	typedef logic [`DRAM_DATA_W-1:0] dram_word_t;
	typedef logic [7:0] byte_t;
	typedef logic [1:0] bsel_t;
	typedef logic [`DRAM_RA_W-1:0] ra_t;
	typedef logic [`DMA_LEN_W-1:0] dma_len_t;

	// four fclk phases of one DRAM cycle
	typedef enum logic [1:0] {ph_c0, ph_c1, ph_c2, ph_c3} phase_t;

	typedef enum logic [1:0] {cyc_idle, cyc_read, cyc_write, cyc_refresh} cyc_kind_t;

	typedef struct packed {
		word_addr_t addr;
		logic rnw;
		bsel_t bsel;
		dram_word_t wrdata;
	} mem_req_s;

	typedef struct packed {
		cyc_kind_t kind;
		word_addr_t addr;
		bsel_t bsel;
		dram_word_t wrdata;
	} dram_cycle_s;

	typedef struct packed {
		byte_addr_t addr;
		logic rnw;
		byte_t wrdata;
	} cpu_cmd_s;

	typedef struct packed {
		word_addr_t src;
		word_addr_t dst;
		dma_len_t len;
	} dma_cmd_s;

	typedef enum logic [1:0] {cs_idle, cs_want, cs_rdwait, cs_ack} cpu_state_t;

	typedef enum logic [2:0] {ds_idle, ds_rd, ds_rdwait, ds_wr, ds_ack} dma_state_t;

endpackage

//--- tsconf_settings.svh
`ifndef TSCONF_SETTINGS_SVH
`define TSCONF_SETTINGS_SVH

// word address and data widths of the DRAM
`define DRAM_ADDR_W 21
`define DRAM_DATA_W 16

// multiplexed row/column address pins
`define DRAM_RA_W 10

// address bit that picks rras0_n or rras1_n
`define BANK_BIT 20

// fclk cycles between refresh requests
`define REFRESH_INTERVAL 64

`define DMA_LEN_W 8

`endif
